// File: gb_io.f
gb_io_pkg.sv
io_decode.sv
joypad_port.sv
serial_port.sv
irq_ctrl.sv
work_ram.sv
read_return.sv
gb_io_top.sv
gb_io_assert.sv
tb_gb_io.sv

// File: Bender.yml
package:
  name: gb_io

sources:
  - gb_io_pkg.sv
  - io_decode.sv
  - joypad_port.sv
  - serial_port.sv
  - irq_ctrl.sv
  - work_ram.sv
  - read_return.sv
  - gb_io_top.sv
  - target: test
    files:
      - gb_io_assert.sv
      - tb_gb_io.sv

// File: tb_gb_io.sv
// directed testbench for the console I/O block
// cpu-side bus tasks, per-feature tests, value check and cycle limit
`timescale 1ns/1ps

module tb_gb_io;

	localparam int CYCLE_LIMIT = 8000; // serial transfer alone is ~4200
	localparam int SERIAL_WAIT = 4600;
	localparam int RAM_N       = 6;    // samples per wram region

	logic                clk_cpu;
	logic                reset;
	gb_io_pkg::bus_req_t bus;
	logic [7:0]          joystick;
	logic                vblank, lcd_irq, timer_irq, irq_ack;
	logic [7:0]          rd_data;
	logic                rd_valid;
	logic                irq;
	logic [7:0]          irq_vec;

	integer seed      = 32'ha890;
	int     cycle_cnt = 0;

	gb_io_top i_gb_io_top (
		.clk_cpu   (clk_cpu),
		.reset     (reset),
		.bus       (bus),
		.joystick  (joystick),
		.vblank    (vblank),
		.lcd_irq   (lcd_irq),
		.timer_irq (timer_irq),
		.irq_ack   (irq_ack),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.irq       (irq),
		.irq_vec   (irq_vec)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #50 clk_cpu = ~clk_cpu; // 100 ns period
	end

	// cycle limit and bound assertion watch
	always @(posedge clk_cpu) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$fatal(1, "run aborted");
		end else if (i_gb_io_top.i_gb_io_assert.fail_cnt != 0) begin
			$display("a bound protocol assertion failed");
			$display("** FAIL **");
			$fatal(1, "assertion failure");
		end
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "check failed");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_cpu);
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_cpu);
		bus <= '{addr, data, 1'b0, 1'b1};
		@(posedge clk_cpu);
		bus <= '0;                      // decode samples here
		repeat (2) @(posedge clk_cpu); // unit takes it one edge later
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk_cpu);
		bus <= '{addr, 8'h00, 1'b1, 1'b0};
		@(posedge clk_cpu);
		bus <= '0;
		do begin
			@(posedge clk_cpu);
		end while (!rd_valid); // value from before the edge
		data = rd_data;
	endtask

	task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] d;
		bus_read(addr, d);
		check_value($sformatf("rd_data[%h]", addr), d, exp);
	endtask

	// falling edge of irq_ack clears one flag
	task automatic ack_irq();
		@(posedge clk_cpu);
		irq_ack <= 1'b1;
		@(posedge clk_cpu);
		irq_ack <= 1'b0;
		repeat (2) @(posedge clk_cpu);
	endtask

	// expected P1 byte with dir lines on buttons 0 1 3 2 and action lines on 4..7
	function automatic logic [7:0] joyp_expect(input logic [1:0] sel, input logic [7:0] btn);
		logic [3:0] dir;
		logic [3:0] act;
		dir[0] = ~btn[0];
		dir[1] = ~btn[1];
		dir[2] = ~btn[3];
		dir[3] = ~btn[2];
		act    = ~btn[7:4];
		if (sel[0])
			dir = 4'hf; // P14 high turns the group off
		if (sel[1])
			act = 4'hf;
		return {2'b11, sel, dir & act};
	endfunction

	function automatic logic [15:0] c_region_addr(input int k);
		return 16'hc000 | (16'(k * 16'h2a3) & 16'h0fff);
	endfunction

	function automatic logic [15:0] d_region_addr(input int k);
		return 16'hd000 | (16'(k * 16'h2a3 + 16'h17) & 16'h0fff);
	endfunction

	// ------------------------------
	// tests
	// ------------------------------
	task automatic reset_values();
		expect_read(gb_io_pkg::ADDR_IE, 8'h00);
		expect_read(gb_io_pkg::ADDR_IF, 8'he0);   // top bits read high
		expect_read(gb_io_pkg::ADDR_SVBK, 8'hf9); // bank 1
		expect_read(gb_io_pkg::ADDR_SC, 8'h7e);
		expect_read(gb_io_pkg::ADDR_SB, 8'hff);
		expect_read(gb_io_pkg::ADDR_JOYP, 8'hcf); // nothing pressed
		expect_read(16'hff03, 8'hff);             // unmapped
		expect_read(16'h8000, 8'hff);
		expect_read(16'hff7f, 8'hff);
	endtask

	task automatic banked_wram();
		logic [7:0] c_exp [RAM_N];
		logic [7:0] d_exp [3][RAM_N];
		int         banks [3] = '{1, 3, 7};
		for (int k = 0; k < RAM_N; k++) begin
			c_exp[k] = 8'($random(seed));
			bus_write(c_region_addr(k), c_exp[k]);
		end
		for (int b = 0; b < 3; b++) begin
			bus_write(gb_io_pkg::ADDR_SVBK, 8'(banks[b]));
			for (int k = 0; k < RAM_N; k++) begin
				d_exp[b][k] = 8'($random(seed));
				bus_write(d_region_addr(k), d_exp[b][k]);
			end
		end
		// read back per bank with the shared c000 half
		for (int b = 0; b < 3; b++) begin
			bus_write(gb_io_pkg::ADDR_SVBK, 8'(banks[b]));
			expect_read(gb_io_pkg::ADDR_SVBK, 8'hf8 | 8'(banks[b]));
			for (int k = 0; k < RAM_N; k++) begin
				expect_read(d_region_addr(k), d_exp[b][k]);
				expect_read(c_region_addr(k), c_exp[k]);
			end
		end
		bus_write(gb_io_pkg::ADDR_SVBK, 8'h00); // maps to bank 1
		expect_read(gb_io_pkg::ADDR_SVBK, 8'hf9);
	endtask

	task automatic zero_page_burst();
		logic [7:0] zp_exp [127];
		int         issued;
		int         got;
		for (int i = 0; i < 127; i++) begin
			zp_exp[i] = 8'($random(seed));
			bus_write(16'hff80 + 16'(i), zp_exp[i]);
		end
		issued = 0;
		got    = 0;
		// one read per cycle with results in order
		while (got < 127) begin
			@(posedge clk_cpu);
			if (rd_valid) begin
				check_value($sformatf("rd_data[%h]", 16'hff80 + 16'(got)), rd_data, zp_exp[got]);
				got++;
			end
			if (issued < 127) begin
				bus <= '{16'hff80 + 16'(issued), 8'h00, 1'b1, 1'b0};
				issued++;
			end else
				bus <= '0;
		end
	endtask

	task automatic joypad_matrix();
		logic [7:0] pats [6] = '{8'h00, 8'h01, 8'h0a, 8'h84, 8'hf0, 8'hff};
		for (int s = 0; s < 4; s++) begin
			for (int p = 0; p < 6; p++) begin
				@(posedge clk_cpu);
				joystick <= pats[p];
				bus_write(gb_io_pkg::ADDR_JOYP, 8'(s << 4)); // P15 P14 on bits 5:4
				expect_read(gb_io_pkg::ADDR_JOYP, joyp_expect(2'(s), pats[p]));
			end
		end
		// press detect with both groups on
		@(posedge clk_cpu);
		joystick <= 8'h00;
		bus_write(gb_io_pkg::ADDR_JOYP, 8'h00);
		bus_write(gb_io_pkg::ADDR_IF, 8'h00);
		expect_read(gb_io_pkg::ADDR_IF, 8'he0);
		@(posedge clk_cpu);
		joystick <= 8'h20; // button 5
		idle_cycles(3);    // two-flop history plus flag edge
		expect_read(gb_io_pkg::ADDR_JOYP, joyp_expect(2'b00, 8'h20));
		expect_read(gb_io_pkg::ADDR_IF, 8'hf0);
		@(posedge clk_cpu);
		joystick <= 8'h00;
		bus_write(gb_io_pkg::ADDR_IF, 8'h00);
	endtask

	task automatic irq_priority();
		bus_write(gb_io_pkg::ADDR_IF, 8'h00);
		bus_write(gb_io_pkg::ADDR_IE, 8'h07); // vblank lcd timer
		check_value("irq", irq, 1'b0);
		check_value("irq_vec", irq_vec, 8'h55);
		@(posedge clk_cpu);
		lcd_irq   <= 1'b1;
		timer_irq <= 1'b1;
		vblank    <= 1'b1;
		@(posedge clk_cpu);
		lcd_irq   <= 1'b0;
		timer_irq <= 1'b0;
		idle_cycles(3);
		check_value("irq", irq, 1'b1);
		check_value("irq_vec", irq_vec, 8'h40);
		expect_read(gb_io_pkg::ADDR_IF, 8'he7);
		// one flag per ack in priority order
		ack_irq();
		check_value("irq_vec", irq_vec, 8'h48);
		ack_irq();
		check_value("irq_vec", irq_vec, 8'h50);
		ack_irq();
		check_value("irq_vec", irq_vec, 8'h55);
		check_value("irq", irq, 1'b0);
		@(posedge clk_cpu);
		vblank <= 1'b0;
		// direct flag writes
		bus_write(gb_io_pkg::ADDR_IF, 8'h1f);
		check_value("irq_vec", irq_vec, 8'h40);
		expect_read(gb_io_pkg::ADDR_IF, 8'hff);
		bus_write(gb_io_pkg::ADDR_IF, 8'h10); // joypad flag without its enable
		repeat (5) begin
			@(posedge clk_cpu);
			check_value("irq", irq, 1'b0);
			check_value("irq_vec", irq_vec, 8'h55);
		end
		bus_write(gb_io_pkg::ADDR_IE, 8'h1f);
		check_value("irq", irq, 1'b1);
		check_value("irq_vec", irq_vec, 8'h60); // source 4
		expect_read(gb_io_pkg::ADDR_IE, 8'h1f);
		bus_write(gb_io_pkg::ADDR_IE, 8'h00);
		bus_write(gb_io_pkg::ADDR_IF, 8'h00);
	endtask

	task automatic serial_transfer();
		logic [7:0] d;
		int         start_cyc;
		bus_write(gb_io_pkg::ADDR_IF, 8'h00);
		bus_write(gb_io_pkg::ADDR_SC, 8'h81); // start with internal clock
		start_cyc = cycle_cnt;
		bus_read(gb_io_pkg::ADDR_SC, d);
		check_value("rd_data[ff02]", d, 8'hff);
		// poll until start bit drops
		while (d[7]) begin
			if (cycle_cnt - start_cyc > SERIAL_WAIT) begin
				$display("serial transfer still busy after %0d cycles", SERIAL_WAIT);
				$display("** FAIL **");
				$fatal(1, "serial transfer never finished");
			end
			bus_read(gb_io_pkg::ADDR_SC, d);
		end
		check_value("rd_data[ff02]", d, 8'h7f);
		expect_read(gb_io_pkg::ADDR_IF, 8'he8); // serial flag
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		bus       = '0;
		joystick  = 8'h00;
		vblank    = 1'b0;
		lcd_irq   = 1'b0;
		timer_irq = 1'b0;
		irq_ack   = 1'b0;
		reset     = 1'b1;
		repeat (4) @(posedge clk_cpu);
		reset <= 1'b0;

		reset_values();
		banked_wram();
		zero_page_burst();
		joypad_matrix();
		irq_priority();
		serial_transfer();
		idle_cycles(4); // let the bound checks see the tail

		if (i_gb_io_top.i_gb_io_assert.fail_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: gb_io_assert.sv
// concurrent checks on the top-level bus, read return and irq outputs
// bound into gb_io_top
`timescale 1ns/1ps

module gb_io_assert (
	input logic                 clk_cpu,
	input logic                 reset,
	input gb_io_pkg::bus_req_t  bus,
	input logic                 rd_valid,
	input logic                 irq,
	input logic [7:0]           irq_vec
);

	int fail_cnt = 0; // failures seen so far, checked at end of run

	// ------------------------------
	// read return timing
	// ------------------------------
	// valid rises on the latency edge, so the next sample sees it
	a_rd_latency: assert property (@(posedge clk_cpu) disable iff (reset)
		rd_valid == $past(bus.rd, gb_io_pkg::READ_LATENCY + 1))
	else begin
		fail_cnt++;
		$error("rd_valid out of step with the read strobes");
	end

	a_rd_wr_excl: assert property (@(posedge clk_cpu) !(bus.rd && bus.wr))
	else begin
		fail_cnt++;
		$error("rd and wr strobes high in the same cycle");
	end

	// no source pending means the idle vector
	a_vec_idle: assert property (@(posedge clk_cpu) disable iff (reset)
		!irq |-> irq_vec == gb_io_pkg::IRQ_VEC_NONE)
	else begin
		fail_cnt++;
		$error("irq_vec not idle while irq is low");
	end

	a_reset_quiet: assert property (@(posedge clk_cpu)
		reset && $past(reset) |-> !rd_valid)
	else begin
		fail_cnt++;
		$error("rd_valid high during reset");
	end

endmodule

bind gb_io_top gb_io_assert i_gb_io_assert (.*);

// File: gb_io_top.sv
// console I/O and memory block, three-stage access pipeline
// decode -> unit access -> read return
`timescale 1ns/1ps

module gb_io_top (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_io_pkg::bus_req_t  bus,
	input  logic [7:0]           joystick,  // 1 = pressed
	input  logic                 vblank,
	input  logic                 lcd_irq,
	input  logic                 timer_irq,
	input  logic                 irq_ack,
	output logic [7:0]           rd_data,
	output logic                 rd_valid,
	output logic                 irq,
	output logic [7:0]           irq_vec
);

	gb_io_pkg::io_req_t req; // stage 1 -> units

	logic [7:0] joyp_byte, serial_byte, irq_byte, ram_byte;
	logic       joyp_sel, serial_sel, irq_sel, ram_sel;
	logic       joy_press;
	logic       serial_done;

	// ------------------------------
	// stage 1
	// ------------------------------
	io_decode i_io_decode (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus),
		.req     (req)
	);

	// ------------------------------
	// stage 2, units
	// ------------------------------
	joypad_port i_joypad_port (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.req      (req),
		.joystick (joystick),
		.rd_byte  (joyp_byte),
		.rd_sel   (joyp_sel),
		.press    (joy_press)
	);

	serial_port i_serial_port (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.req     (req),
		.rd_byte (serial_byte),
		.rd_sel  (serial_sel),
		.done    (serial_done)
	);

	irq_ctrl i_irq_ctrl (
		.clk_cpu     (clk_cpu),
		.reset       (reset),
		.req         (req),
		.lcd_irq     (lcd_irq),
		.timer_irq   (timer_irq),
		.vblank      (vblank),
		.serial_done (serial_done),
		.joy_press   (joy_press),
		.irq_ack     (irq_ack),
		.rd_byte     (irq_byte),
		.rd_sel      (irq_sel),
		.irq         (irq),
		.irq_vec     (irq_vec)
	);

	work_ram i_work_ram (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.req     (req),
		.rd_byte (ram_byte),
		.rd_sel  (ram_sel)
	);

	// ------------------------------
	// stage 3
	// ------------------------------
	read_return i_read_return (
		.clk_cpu     (clk_cpu),
		.reset       (reset),
		.sel         (req.sel),
		.rd_pending  (req.bus.rd),
		.joyp_byte   (joyp_byte),
		.joyp_sel    (joyp_sel),
		.serial_byte (serial_byte),
		.serial_sel  (serial_sel),
		.irq_byte    (irq_byte),
		.irq_sel     (irq_sel),
		.ram_byte    (ram_byte),
		.ram_sel     (ram_sel),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid)
	);

endmodule

// File: read_return.sv
// pipeline stage 3, read data select and read-valid
`timescale 1ns/1ps

module read_return (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::io_sel_t  sel,        // stage 2 selects
	input  logic                rd_pending, // stage 2 read strobe
	input  logic [7:0]          joyp_byte,
	input  logic                joyp_sel,
	input  logic [7:0]          serial_byte,
	input  logic                serial_sel,
	input  logic [7:0]          irq_byte,
	input  logic                irq_sel,
	input  logic [7:0]          ram_byte,
	input  logic                ram_sel,
	output logic [7:0]          rd_data,
	output logic                rd_valid
);

	logic rd_q;     // read in unit stage
	logic mapped_q; // some unit claimed the address

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_q     <= 1'b0;
			mapped_q <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_q     <= rd_pending;
			mapped_q <= |sel;
			rd_valid <= rd_q; // writes never return
		end
	end

	// unit selects are one-hot, and-or mux
	always_ff @(posedge clk_cpu) begin
		if (!mapped_q)
			rd_data <= 8'hff; // open bus
		else
			rd_data <= ({8{joyp_sel}}   & joyp_byte)   |
			           ({8{serial_sel}} & serial_byte) |
			           ({8{irq_sel}}    & irq_byte)    |
			           ({8{ram_sel}}    & ram_byte);
	end

endmodule

// File: work_ram.sv
// banked work ram with SVBK, and the 127-byte zero-page ram
`timescale 1ns/1ps

module work_ram (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::io_req_t  req,
	output logic [7:0]          rd_byte,
	output logic                rd_sel
);

	logic [7:0] wram_mem [2**gb_io_pkg::WRAM_ADDR_W];
	logic [7:0] zp_mem [(2**gb_io_pkg::ZPRAM_ADDR_W) - 1]; // ffff is not ram

	logic [gb_io_pkg::WRAM_BANK_W-1:0] svbk;      // 1..7
	logic [gb_io_pkg::WRAM_ADDR_W-1:0] wram_addr;
	logic [7:0] wram_q;
	logic [7:0] zp_q;
	logic       wram_hit_q; // which source the read came from
	logic       zp_hit_q;

	// d000 half follows SVBK, c000 half is always bank 0
	assign wram_addr = ((req.bus.addr & 16'hf000) == gb_io_pkg::WRAM_BANK_BASE) ?
	                   {svbk, req.bus.addr[11:0]} :
	                   {{gb_io_pkg::WRAM_BANK_W{1'b0}}, req.bus.addr[11:0]};

	// ------------------------------
	// bank register
	// ------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset)
			svbk <= gb_io_pkg::WRAM_BANK_W'(1);
		else if (req.sel.svbk && req.bus.wr) begin
			if (req.bus.wdata[gb_io_pkg::WRAM_BANK_W-1:0] == '0)
				svbk <= gb_io_pkg::WRAM_BANK_W'(1); // bank 0 maps to 1
			else
				svbk <= req.bus.wdata[gb_io_pkg::WRAM_BANK_W-1:0];
		end
	end

	// ------------------------------
	// ram arrays
	// ------------------------------
	always_ff @(posedge clk_cpu) begin
		if (req.sel.wram && req.bus.wr)
			wram_mem[wram_addr] <= req.bus.wdata;
		wram_q <= wram_mem[wram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (req.sel.zpram && req.bus.wr)
			zp_mem[req.bus.addr[gb_io_pkg::ZPRAM_ADDR_W-1:0]] <= req.bus.wdata;
		zp_q <= zp_mem[req.bus.addr[gb_io_pkg::ZPRAM_ADDR_W-1:0]];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_sel     <= 1'b0;
			wram_hit_q <= 1'b0;
			zp_hit_q   <= 1'b0;
		end else begin
			rd_sel     <= req.sel.wram | req.sel.zpram | req.sel.svbk;
			wram_hit_q <= req.sel.wram;
			zp_hit_q   <= req.sel.zpram;
		end
	end

	// SVBK reads with the unused bits high
	assign rd_byte = wram_hit_q ? wram_q :
	                 zp_hit_q   ? zp_q   :
	                 {{(8 - gb_io_pkg::WRAM_BANK_W){1'b1}}, svbk};

endmodule

// File: irq_ctrl.sv
// interrupt controller: IF/IE, event capture, priority vector, ack clear
`timescale 1ns/1ps

module irq_ctrl (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::io_req_t  req,
	input  logic                lcd_irq,     // pulse
	input  logic                timer_irq,   // pulse
	input  logic                vblank,      // level
	input  logic                serial_done, // pulse
	input  logic                joy_press,   // pulse
	input  logic                irq_ack,     // level from cpu
	output logic [7:0]          rd_byte,
	output logic                rd_sel,
	output logic                irq,
	output logic [7:0]          irq_vec
);

	gb_io_pkg::irq_bits_t if_r;    // flags
	gb_io_pkg::irq_bits_t ie_r;    // enables
	gb_io_pkg::irq_bits_t if_next;
	gb_io_pkg::irq_bits_t pend;    // flagged and enabled
	gb_io_pkg::irq_bits_t pend_top; // lowest set bit of pend

	logic vs_d, vs_d2; // vblank edge detect
	logic ack_d;
	logic ack_fall;

	assign pend     = if_r & ie_r;
	assign pend_top = pend & (~pend + 1'b1); // isolate highest priority
	assign ack_fall = ack_d & ~irq_ack;

	// ------------------------------
	// flag next state
	// ------------------------------
	always_comb begin
		if_next = if_r;
		if (vs_d && !vs_d2)
			if_next[gb_io_pkg::IRQ_VBLANK] = 1'b1;
		if (lcd_irq)
			if_next[gb_io_pkg::IRQ_LCD] = 1'b1;
		if (timer_irq)
			if_next[gb_io_pkg::IRQ_TIMER] = 1'b1;
		if (serial_done)
			if_next[gb_io_pkg::IRQ_SERIAL] = 1'b1;
		if (joy_press)
			if_next[gb_io_pkg::IRQ_JOYPAD] = 1'b1;
		// ack takes the serviced flag away
		if (ack_fall)
			if_next = if_next & ~pend_top;
		// cpu write wins over everything
		if (req.sel.if_reg && req.bus.wr)
			if_next = req.bus.wdata[gb_io_pkg::IRQ_N-1:0];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			vs_d  <= 1'b0;
			vs_d2 <= 1'b0;
			ack_d <= 1'b0;
		end else begin
			if_r  <= if_next;
			vs_d  <= vblank;
			vs_d2 <= vs_d;
			ack_d <= irq_ack;
			if (req.sel.ie_reg && req.bus.wr)
				ie_r <= req.bus.wdata[gb_io_pkg::IRQ_N-1:0];
		end
	end

	// register reads, unused IF bits read as ones
	always_ff @(posedge clk_cpu) begin
		rd_byte <= req.sel.if_reg ? {3'b111, if_r} : {3'b000, ie_r};
		if (reset)
			rd_sel <= 1'b0;
		else
			rd_sel <= req.sel.if_reg | req.sel.ie_reg;
	end

	// ------------------------------
	// request and vector
	// ------------------------------
	assign irq = |pend;

	always_comb begin
		irq_vec = gb_io_pkg::IRQ_VEC_NONE;
		for (int i = gb_io_pkg::IRQ_N - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vec = 8'(gb_io_pkg::IRQ_VEC_BASE + gb_io_pkg::IRQ_VEC_STEP * i);
		end
	end

endmodule

// File: serial_port.sv
// dummy serial port: SB, SC and the timed transfer-done pulse
`timescale 1ns/1ps

module serial_port (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::io_req_t  req,
	output logic [7:0]          rd_byte,
	output logic                rd_sel,
	output logic                done
);

	logic sc_start;      // SC bit 7, transfer busy
	logic sc_shiftclock; // SC bit 0, internal clock
	logic [$clog2(gb_io_pkg::SERIAL_BIT_CYCLES)-1:0] div;  // bit period
	logic [$clog2(gb_io_pkg::SERIAL_BITS+1)-1:0]     bits; // bits left
	logic sc_wr;

	assign sc_wr = req.sel.sc && req.bus.wr;

	// ------------------------------
	// transfer timing
	// ------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start      <= 1'b0;
			sc_shiftclock <= 1'b0;
			div           <= '1;
			bits          <= '0;
			done          <= 1'b0;
		end else begin
			done <= 1'b0; // single cycle pulse
			if (sc_wr) begin
				sc_start      <= req.bus.wdata[7];
				sc_shiftclock <= req.bus.wdata[0];
				if (req.bus.wdata[7]) begin
					div  <= $bits(div)'(gb_io_pkg::SERIAL_BIT_CYCLES - 1);
					bits <= $bits(bits)'(gb_io_pkg::SERIAL_BITS);
				end
			end else if (sc_start && sc_shiftclock) begin
				div <= div - 1'b1; // wraps every bit period
				if (div == '0 && bits != '0)
					bits <= bits - 1'b1;
				if (bits == '0) begin
					done     <= 1'b1; // raise serial irq
					sc_start <= 1'b0;
				end
			end
		end
	end

	// SB is not backed by storage, reads FF
	always_ff @(posedge clk_cpu) begin
		rd_byte <= req.sel.sc ? {sc_start, 6'h3f, sc_shiftclock} : 8'hff;
		if (reset)
			rd_sel <= 1'b0;
		else
			rd_sel <= req.sel.sb | req.sel.sc;
	end

endmodule

// File: joypad_port.sv
// joypad P1 register, button matrix read and press detect
`timescale 1ns/1ps

module joypad_port (
	input  logic                clk_cpu,
	input  logic                reset,
	input  gb_io_pkg::io_req_t  req,
	input  logic [7:0]          joystick, // 1 = pressed
	output logic [7:0]          rd_byte,
	output logic                rd_sel,
	output logic                press
);

	logic [1:0] p54;       // P15/P14 select, 1 = group off
	logic [3:0] joy_dir;   // right left up down, active low
	logic [3:0] joy_act;   // a b select start, active low
	logic [7:0] hist1;
	logic [7:0] hist2;

	// group lines float high when deselected
	assign joy_dir = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_act = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p54 <= 2'b00;
		else if (req.sel.joyp && req.bus.wr)
			p54 <= req.bus.wdata[5:4]; // only select bits writable
	end

	// read path
	always_ff @(posedge clk_cpu) begin
		rd_byte <= {2'b11, p54, joy_dir & joy_act};
		if (reset)
			rd_sel <= 1'b0;
		else
			rd_sel <= req.sel.joyp;
	end

	// line history, idle high
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			hist1 <= '1;
			hist2 <= '1;
		end else begin
			hist1 <= {joy_dir, joy_act};
			hist2 <= hist1;
		end
	end

	assign press = |(hist2 & ~hist1); // any high-to-low line

endmodule

// File: io_decode.sv
// pipeline stage 1
// registers the cpu bus and decodes the address into unit selects
`timescale 1ns/1ps

module io_decode (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_io_pkg::bus_req_t  bus,
	output gb_io_pkg::io_req_t   req
);

	gb_io_pkg::io_sel_t sel; // decode of the incoming address

	// ------------------------------
	// address decode
	// ------------------------------
	always_comb begin
		sel        = '0;
		sel.joyp   = (bus.addr == gb_io_pkg::ADDR_JOYP);
		sel.sb     = (bus.addr == gb_io_pkg::ADDR_SB);
		sel.sc     = (bus.addr == gb_io_pkg::ADDR_SC);
		sel.if_reg = (bus.addr == gb_io_pkg::ADDR_IF);
		sel.ie_reg = (bus.addr == gb_io_pkg::ADDR_IE);
		sel.svbk   = (bus.addr == gb_io_pkg::ADDR_SVBK);
		// c000-dfff, no echo
		sel.wram   = ((bus.addr & 16'he000) == gb_io_pkg::WRAM_BASE);
		// ff80-fffe, ffff is IE
		sel.zpram  = ((bus.addr & 16'hff80) == gb_io_pkg::ZPRAM_BASE) &&
		             (bus.addr != gb_io_pkg::ADDR_IE);
	end

	// payload, no reset needed
	always_ff @(posedge clk_cpu) begin
		req.bus.addr  <= bus.addr;
		req.bus.wdata <= bus.wdata;
	end

	// strobes and selects
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			req.bus.rd <= 1'b0;
			req.bus.wr <= 1'b0;
			req.sel    <= '0;
		end else begin
			req.bus.rd <= bus.rd;
			req.bus.wr <= bus.wr;
			req.sel    <= sel; // unmapped -> all zero
		end
	end

endmodule

// File: gb_io_pkg.sv
// shared constants and bus types for the console I/O block
// register map, interrupt numbering, serial timing, pipeline structs
package gb_io_pkg;

	// ------------------------------
	// register addresses
	// ------------------------------
	localparam logic [15:0] ADDR_JOYP = 16'hff00; // P1 joypad
	localparam logic [15:0] ADDR_SB   = 16'hff01; // serial data
	localparam logic [15:0] ADDR_SC   = 16'hff02; // serial control
	localparam logic [15:0] ADDR_IF   = 16'hff0f; // interrupt flags
	localparam logic [15:0] ADDR_SVBK = 16'hff70; // wram bank select
	localparam logic [15:0] ADDR_IE   = 16'hffff; // interrupt enable

	// memory windows
	localparam logic [15:0] WRAM_BASE      = 16'hc000; // 8k window, bank 0 half
	localparam logic [15:0] WRAM_BANK_BASE = 16'hd000; // switchable half
	localparam logic [15:0] ZPRAM_BASE     = 16'hff80; // high ram

	localparam int unsigned WRAM_BANK_W  = 3;  // bank number bits
	localparam int unsigned WRAM_ADDR_W  = 15; // 32 KiB total
	localparam int unsigned ZPRAM_ADDR_W = 7;

	// ------------------------------
	// interrupts
	// ------------------------------
	localparam int unsigned IRQ_N = 5;

	// lower index wins
	localparam int unsigned IRQ_VBLANK = 0;
	localparam int unsigned IRQ_LCD    = 1;
	localparam int unsigned IRQ_TIMER  = 2;
	localparam int unsigned IRQ_SERIAL = 3;
	localparam int unsigned IRQ_JOYPAD = 4;

	localparam logic [7:0] IRQ_VEC_BASE = 8'h40; // rst vector of source 0
	localparam logic [7:0] IRQ_VEC_STEP = 8'h08;
	localparam logic [7:0] IRQ_VEC_NONE = 8'h55; // nothing pending

	// serial timing, one bit every 512 cpu clocks
	localparam int unsigned SERIAL_BIT_CYCLES = 512;
	localparam int unsigned SERIAL_BITS       = 8;

	// edges from rd sample to rd_valid
	localparam int unsigned READ_LATENCY = 2;

	// ------------------------------
	// bus types
	// ------------------------------
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} bus_req_t; // 26 bits

	// one-hot unit selects
	typedef struct packed {
		logic joyp;
		logic sb;
		logic sc;
		logic if_reg;
		logic ie_reg;
		logic svbk;
		logic wram;
		logic zpram;
	} io_sel_t; // 8 bits

	// decoded request, stage 1 output
	typedef struct packed {
		bus_req_t bus;
		io_sel_t  sel;
	} io_req_t; // 34 bits

	typedef logic [IRQ_N-1:0] irq_bits_t; // one bit per source

endpackage
